// ==== hw/decode_frontend.sv ====
module decode_frontend (
	input logic clk,
	input logic rst,
	input logic mem_strobe,
	input logic [31:0] mem_instr,
	input logic mem_fault,
	input logic redirect,
	input logic [31:0] redirect_pc,
	input logic hold,
	output logic [3:0] ra_sel,
	output logic [3:0] rb_sel,
	output logic [3:0] rd_sel,
	output logic update_rd,
	output logic alu_op1_ra,
	output logic alu_op1_rb,
	output logic alu_op2_rb,
	output logic [31:0] imm32,
	output logic [4:0] alu_opc,
	output logic [2:0] branch_condition,
	output logic mem_load,
	output logic mem_store,
	output logic [1:0] mem_width,
	output logic [31:0] pc_plus_4_out,
	output logic [1:0] instr_class,
	output logic is_call,
	output logic update_flags,
	output logic update_carry,
	output logic [2:0] cr_sel,
	output logic write_cr,
	output logic is_swi,
	output logic is_rfe,
	output logic illegal_instr,
	output logic exception_start_out,
	output logic bkpt_hit,
	output logic i_valid,
	output logic queue_overflow
);

	logic flush;

	fetch_bus_if fetch_in ();
	fetch_bus_if decode_in ();

	fetch_sequencer u_fetch (
		.clk(clk),
		.rst(rst),
		.mem_strobe(mem_strobe),
		.mem_instr(mem_instr),
		.mem_fault(mem_fault),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.flush(flush),
		.out_bus(fetch_in.producer)
	);

	instr_queue u_queue (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.hold(hold),
		.in_bus(fetch_in.consumer),
		.out_bus(decode_in.producer),
		.overflow(queue_overflow)
	);

	instr_decode u_decode (
		.clk(clk),
		.rst(rst),
		.in_bus(decode_in.consumer),
		.ra_sel(ra_sel),
		.rb_sel(rb_sel),
		.rd_sel(rd_sel),
		.update_rd(update_rd),
		.alu_op1_ra(alu_op1_ra),
		.alu_op1_rb(alu_op1_rb),
		.alu_op2_rb(alu_op2_rb),
		.imm32(imm32),
		.alu_opc(alu_opc),
		.branch_condition(branch_condition),
		.mem_load(mem_load),
		.mem_store(mem_store),
		.mem_width(mem_width),
		.pc_plus_4_out(pc_plus_4_out),
		.instr_class(instr_class),
		.is_call(is_call),
		.update_flags(update_flags),
		.update_carry(update_carry),
		.cr_sel(cr_sel),
		.write_cr(write_cr),
		.is_swi(is_swi),
		.is_rfe(is_rfe),
		.illegal_instr(illegal_instr),
		.exception_start_out(exception_start_out),
		.bkpt_hit(bkpt_hit),
		.i_valid(i_valid)
	);

endmodule

// ==== hw/fetch_bus_if.sv ====
interface fetch_bus_if;

	logic strobe; // one cycle per word, no back-pressure
	logic [31:0] instr;
	logic [31:0] pc_plus_4;
	logic fault;

	modport producer (
		output strobe,
		output instr,
		output pc_plus_4,
		output fault
	);

	modport consumer (
		input strobe,
		input instr,
		input pc_plus_4,
		input fault
	);

endinterface

// ==== hw/fetch_sequencer.sv ====
module fetch_sequencer (
	input logic clk,
	input logic rst,
	input logic mem_strobe,
	input logic [31:0] mem_instr,
	input logic mem_fault,
	input logic redirect,
	input logic [31:0] redirect_pc,
	output logic flush,
	fetch_bus_if.producer out_bus
);
	import oldland_pkg::*;

	logic [31:0] pc;
	logic [31:0] pc_next;
	logic accept;

	assign pc_next = pc + 32'd4;
	assign accept = mem_strobe && !redirect; // a word racing the redirect is stale

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_vector;
			flush <= 1'b0;
			out_bus.strobe <= 1'b0;
		end else begin
			flush <= redirect;
			out_bus.strobe <= accept;
			if (redirect) begin
				pc <= redirect_pc;
			end else if (accept) begin
				pc <= pc_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_bus.instr <= mem_instr;
			out_bus.pc_plus_4 <= pc_next;
			out_bus.fault <= mem_fault;
		end
	end

endmodule

// ==== hw/instr_decode.sv ====
module instr_decode (
	input logic clk,
	input logic rst,
	fetch_bus_if.consumer in_bus,
	output logic [3:0] ra_sel,
	output logic [3:0] rb_sel,
	output logic [3:0] rd_sel,
	output logic update_rd,
	output logic alu_op1_ra,
	output logic alu_op1_rb,
	output logic alu_op2_rb,
	output logic [31:0] imm32,
	output logic [4:0] alu_opc,
	output logic [2:0] branch_condition,
	output logic mem_load,
	output logic mem_store,
	output logic [1:0] mem_width,
	output logic [31:0] pc_plus_4_out,
	output logic [1:0] instr_class,
	output logic is_call,
	output logic update_flags,
	output logic update_carry,
	output logic [2:0] cr_sel,
	output logic write_cr,
	output logic is_swi,
	output logic is_rfe,
	output logic illegal_instr,
	output logic exception_start_out,
	output logic bkpt_hit,
	output logic i_valid
);
	import oldland_pkg::*;

	logic [31:0] instr;
	logic [31:0] uc;
	logic valid;
	logic commit;
	logic is_bkp;
	logic [31:0] imm_next;

	assign instr = in_bus.instr;
	assign uc = microcode_lookup(instr[31:25]);
	assign valid = uc[uc_valid];
	assign commit = in_bus.strobe && !in_bus.fault; // faulted words must not change state
	assign is_bkp = instr[31:30] == class_misc && instr[29:25] == opc_bkp;

	always_comb begin
		case (uc[uc_imsel_hi:uc_imsel_lo])
		imsel_imm13: imm_next = {{19{instr[24]}}, instr[24:12]};
		imsel_imm24: imm_next = {{6{instr[23]}}, instr[23:0], 2'b00}; // word offset
		imsel_hi16: imm_next = {instr[25:10], 16'h0000};
		imsel_lo16: imm_next = {16'h0000, instr[25:10]};
		default: imm_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			i_valid <= 1'b0;
			update_rd <= 1'b0;
			update_flags <= 1'b0;
			update_carry <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			is_call <= 1'b0;
			is_swi <= 1'b0;
			is_rfe <= 1'b0;
			write_cr <= 1'b0;
			illegal_instr <= 1'b0;
			exception_start_out <= 1'b0;
			bkpt_hit <= 1'b0;
			pc_plus_4_out <= '0;
		end else begin
			i_valid <= commit && valid;
			update_rd <= commit && uc[uc_update_rd];
			update_flags <= commit && uc[uc_update_flags];
			update_carry <= commit && uc[uc_update_carry];
			mem_load <= commit && uc[uc_mem_load];
			mem_store <= commit && uc[uc_mem_store];
			is_call <= commit && uc[uc_is_call];
			is_swi <= commit && uc[uc_is_swi];
			is_rfe <= commit && uc[uc_is_rfe];
			write_cr <= commit && uc[uc_write_cr];
			illegal_instr <= in_bus.strobe && !valid;
			exception_start_out <= in_bus.strobe &&
				(!valid || uc[uc_is_swi] || in_bus.fault);
			bkpt_hit <= commit && is_bkp;
			if (in_bus.strobe)
				pc_plus_4_out <= in_bus.pc_plus_4;
		end
	end

	always_ff @(posedge clk) begin
		if (in_bus.strobe) begin
			ra_sel <= instr[11:8];
			rb_sel <= instr[7:4];
			rd_sel <= uc[uc_rd_is_lr] ? link_reg : instr[3:0];
			imm32 <= imm_next;
			alu_opc <= uc[uc_alu_opc_hi:uc_alu_opc_lo];
			branch_condition <= uc[uc_cond_hi:uc_cond_lo];
			alu_op1_ra <= uc[uc_alu_op1_ra];
			alu_op1_rb <= uc[uc_alu_op1_rb];
			alu_op2_rb <= uc[uc_alu_op2_rb];
			mem_width <= uc[uc_width_hi:uc_width_lo];
			instr_class <= instr[31:30];
			cr_sel <= instr[14:12];
		end
	end

endmodule

// ==== hw/instr_queue.sv ====
module instr_queue (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic hold,
	fetch_bus_if.consumer in_bus,
	fetch_bus_if.producer out_bus,
	output logic overflow
);
	import oldland_pkg::*;

	localparam int entry_w = 65;

	logic [entry_w-1:0] mem [queue_depth];
	logic [queue_addr_w-1:0] wr_ptr;
	logic [queue_addr_w-1:0] rd_ptr;
	logic [queue_addr_w:0] count;
	logic empty;
	logic full;
	logic bypass;
	logic push;
	logic pop;
	logic [entry_w-1:0] in_entry;

	assign in_entry = {in_bus.fault, in_bus.pc_plus_4, in_bus.instr};
	assign empty = count == '0;
	assign full = count == (queue_addr_w + 1)'(queue_depth);
	assign bypass = empty && in_bus.strobe && !hold; // empty queue passes the word straight on
	assign pop = !hold && !empty;
	assign push = in_bus.strobe && !full && !bypass;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_bus.strobe <= 1'b0;
			overflow <= 1'b0;
		end else if (flush) begin
			wr_ptr <= '0; // a push arriving with the flush is lost too
			rd_ptr <= '0;
			count <= '0;
			out_bus.strobe <= 1'b0;
		end else begin
			out_bus.strobe <= pop || bypass;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
			if (in_bus.strobe && full)
				overflow <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_entry;
		if (bypass)
			{out_bus.fault, out_bus.pc_plus_4, out_bus.instr} <= in_entry;
		else if (pop)
			{out_bus.fault, out_bus.pc_plus_4, out_bus.instr} <= mem[rd_ptr];
	end

endmodule

// ==== hw/oldland_pkg.sv ====
package oldland_pkg;

	localparam logic [1:0] class_arith = 2'b00;
	localparam logic [1:0] class_branch = 2'b01;
	localparam logic [1:0] class_mem = 2'b10;
	localparam logic [1:0] class_misc = 2'b11;

	// opcode values are only unique within their class
	localparam logic [4:0] opc_add = 5'h00;
	localparam logic [4:0] opc_sub = 5'h01;
	localparam logic [4:0] opc_and = 5'h02;
	localparam logic [4:0] opc_or = 5'h03;
	localparam logic [4:0] opc_movhi = 5'h04;
	localparam logic [4:0] opc_orlo = 5'h05;
	localparam logic [4:0] opc_b = 5'h00;
	localparam logic [4:0] opc_call = 5'h01;
	localparam logic [4:0] opc_ldr = 5'h00;
	localparam logic [4:0] opc_str = 5'h01;
	localparam logic [4:0] opc_swi = 5'h00;
	localparam logic [4:0] opc_rfe = 5'h01;
	localparam logic [4:0] opc_bkp = 5'h02;

	localparam logic [1:0] imsel_imm13 = 2'b00;
	localparam logic [1:0] imsel_imm24 = 2'b01;
	localparam logic [1:0] imsel_hi16 = 2'b10;
	localparam logic [1:0] imsel_lo16 = 2'b11;

	localparam int uc_update_carry = 25;
	localparam int uc_is_rfe = 24;
	localparam int uc_is_swi = 23;
	localparam int uc_write_cr = 22;
	localparam int uc_valid = 21;
	localparam int uc_imsel_hi = 20;
	localparam int uc_imsel_lo = 19;
	localparam int uc_cond_hi = 18;
	localparam int uc_cond_lo = 16;
	localparam int uc_width_hi = 15;
	localparam int uc_width_lo = 14;
	localparam int uc_is_call = 13;
	localparam int uc_rd_is_lr = 12;
	localparam int uc_mem_store = 11;
	localparam int uc_mem_load = 10;
	localparam int uc_alu_op2_rb = 9;
	localparam int uc_alu_op1_rb = 8;
	localparam int uc_alu_op1_ra = 7;
	localparam int uc_update_flags = 6;
	localparam int uc_update_rd = 5;
	localparam int uc_alu_opc_hi = 4;
	localparam int uc_alu_opc_lo = 0;

	localparam logic [2:0] cond_always = 3'b111;
	localparam logic [1:0] width_word = 2'b10;

	localparam logic [31:0] reset_vector = 32'h1000_0000;
	localparam int queue_depth = 8;
	localparam int queue_addr_w = 3;
	localparam logic [3:0] link_reg = 4'd15;

	function automatic logic [31:0] microcode_lookup(input logic [6:0] addr);
		logic [31:0] uc;
		uc = '0;
		uc[uc_valid] = 1'b1;
		case (addr)
		{class_arith, opc_add}, {class_arith, opc_sub}: begin
			uc[uc_alu_op1_ra] = 1'b1;
			uc[uc_alu_op2_rb] = 1'b1;
			uc[uc_update_rd] = 1'b1;
			uc[uc_update_flags] = 1'b1;
			uc[uc_update_carry] = 1'b1;
			uc[uc_alu_opc_hi:uc_alu_opc_lo] = addr[4:0];
		end
		{class_arith, opc_and}, {class_arith, opc_or}: begin
			uc[uc_alu_op1_ra] = 1'b1;
			uc[uc_alu_op2_rb] = 1'b1;
			uc[uc_update_rd] = 1'b1;
			uc[uc_update_flags] = 1'b1;
			uc[uc_alu_opc_hi:uc_alu_opc_lo] = addr[4:0];
		end
		{class_arith, opc_movhi}: begin
			uc[uc_imsel_hi:uc_imsel_lo] = imsel_hi16;
			uc[uc_update_rd] = 1'b1;
			uc[uc_alu_opc_hi:uc_alu_opc_lo] = opc_movhi;
		end
		{class_arith, opc_orlo}: begin
			uc[uc_imsel_hi:uc_imsel_lo] = imsel_lo16;
			uc[uc_alu_op1_ra] = 1'b1; // keeps the upper half of ra
			uc[uc_update_rd] = 1'b1;
			uc[uc_alu_opc_hi:uc_alu_opc_lo] = opc_orlo;
		end
		{class_branch, opc_b}: begin
			uc[uc_imsel_hi:uc_imsel_lo] = imsel_imm24;
			uc[uc_cond_hi:uc_cond_lo] = cond_always;
		end
		{class_branch, opc_call}: begin
			uc[uc_imsel_hi:uc_imsel_lo] = imsel_imm24;
			uc[uc_cond_hi:uc_cond_lo] = cond_always;
			uc[uc_is_call] = 1'b1;
			uc[uc_rd_is_lr] = 1'b1;
			uc[uc_update_rd] = 1'b1; // return address goes to the link register
		end
		{class_mem, opc_ldr}: begin
			uc[uc_alu_op1_ra] = 1'b1; // address is ra plus imm13
			uc[uc_mem_load] = 1'b1;
			uc[uc_update_rd] = 1'b1;
			uc[uc_width_hi:uc_width_lo] = width_word;
		end
		{class_mem, opc_str}: begin
			uc[uc_alu_op1_ra] = 1'b1;
			uc[uc_mem_store] = 1'b1;
			uc[uc_width_hi:uc_width_lo] = width_word;
		end
		{class_misc, opc_swi}: uc[uc_is_swi] = 1'b1;
		{class_misc, opc_rfe}: uc[uc_is_rfe] = 1'b1;
		{class_misc, opc_bkp}: uc[uc_valid] = 1'b1;
		default: uc = '0;
		endcase
		return uc;
	endfunction

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_frontend -o tb_sim

output=$(./obj_dir/tb_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// ==== tests/tb_tasks.svh ====
task automatic test_reset();
	int start;
	start = error_count;
	rst = 1'b1;
	repeat (16) begin
		step();
		check_reset_state();
	end
	rst = 1'b0;
	repeat (4) begin
		step();
		check_reset_state(); // nothing strobed yet, so all stays quiet
	end
	finish_test("reset", start);
endtask

task automatic test_arith();
	logic [4:0] ops [6];
	int start;
	ops = '{opc_add, opc_sub, opc_and, opc_or, opc_movhi, opc_orlo};
	start = error_count;
	for (int i = 0; i < 8; i++)
		run_word(make_word(class_arith, ops[i % 6]), 1'b0);
	finish_test("arith", start);
endtask

task automatic test_branch_mem();
	int start;
	start = error_count;
	run_word(make_word(class_branch, opc_b), 1'b0);
	run_word(make_word(class_branch, opc_call), 1'b0);
	run_word(make_word(class_mem, opc_ldr), 1'b0);
	run_word(make_word(class_mem, opc_str), 1'b0);
	finish_test("branch_mem", start);
endtask

task automatic test_exceptions();
	int start;
	start = error_count;
	run_word(make_word(class_misc, 5'h1f), 1'b0);
	run_word(make_word(class_arith, 5'h10), 1'b0);
	run_word(make_word(class_misc, opc_swi), 1'b0);
	run_word(make_word(class_misc, opc_rfe), 1'b0);
	run_word(make_word(class_arith, opc_add), 1'b1); // memory fault on a legal word
	run_word(make_word(class_misc, opc_bkp), 1'b0);
	finish_test("exceptions", start);
endtask

// strobes n words under hold, then drains the queue and checks the order
task automatic hold_round(input int n);
	logic [31:0] words [$];
	logic [31:0] base;
	bit seen;
	base = exp_pc;
	hold = 1'b1;
	for (int i = 0; i < n; i++) begin
		words.push_back(make_word(class_arith, opc_add));
		mem_instr = words[i];
		mem_strobe = 1'b1;
		step();
		check_val("i_valid under hold", 32'(i_valid), 32'd0);
	end
	mem_strobe = 1'b0;
	exp_pc = base + 32'(4 * n);
	repeat (4) begin
		step();
		check_val("i_valid under hold", 32'(i_valid), 32'd0);
	end
	check_val("queue_overflow", 32'(queue_overflow), 32'(n > queue_depth));
	hold = 1'b0;
	wait_valid(8, seen);
	for (int i = 0; i < queue_depth && seen; i++) begin
		compare_outputs(words[i], model(words[i], 1'b0), base + 32'(4 * (i + 1)));
		step();
	end
	repeat (4) begin
		check_val("i_valid after drain", 32'(i_valid), 32'd0);
		step();
	end
endtask

task automatic test_hold();
	int start;
	start = error_count;
	hold_round(queue_depth);
	finish_test("hold", start);
endtask

task automatic test_overflow();
	int start;
	start = error_count;
	hold_round(queue_depth + 2);
	finish_test("overflow", start);
endtask

task automatic test_redirect();
	logic [31:0] target;
	int start;
	start = error_count;
	target = $urandom() & 32'hffff_fffc;
	hold = 1'b1;
	repeat (3) begin
		mem_instr = make_word(class_arith, opc_or);
		mem_strobe = 1'b1;
		step();
	end
	mem_strobe = 1'b0;
	repeat (2) step();
	redirect = 1'b1;
	redirect_pc = target;
	step();
	redirect = 1'b0;
	repeat (3) step(); // flush reaches the queue before hold drops
	hold = 1'b0;
	repeat (8) begin
		step();
		check_val("i_valid after flush", 32'(i_valid), 32'd0);
	end
	exp_pc = target;
	run_word(make_word(class_arith, opc_sub), 1'b0);
	finish_test("redirect", start);
endtask

// ==== tests/tb_decode_frontend.sv ====
module tb_decode_frontend;
	timeunit 1ns;
	timeprecision 100ps;
	import oldland_pkg::*;

	typedef struct packed {
		logic valid;
		logic i_valid;
		logic illegal;
		logic exc;
		logic is_swi;
		logic is_rfe;
		logic is_call;
		logic bkpt;
		logic update_rd;
		logic update_flags;
		logic update_carry;
		logic op1_ra;
		logic op1_rb;
		logic op2_rb;
		logic mem_load;
		logic mem_store;
		logic [1:0] mem_width;
		logic [4:0] alu_opc;
		logic [2:0] cond;
		logic [1:0] cls;
		logic [2:0] cr;
		logic [31:0] imm;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rd;
	} expect_t;

	localparam int clk_period = 20;
	localparam int reset_cycles = 24;
	localparam int arith_cycles = 40;
	localparam int branch_cycles = 20;
	localparam int exc_cycles = 24;
	localparam int hold_cycles = 80;
	localparam int redirect_cycles = 30;
	localparam int total_cycles = reset_cycles + arith_cycles + branch_cycles + exc_cycles +
		hold_cycles + redirect_cycles;

	logic clk = 1'b0;
	logic rst;
	logic mem_strobe, mem_fault, redirect, hold;
	logic [31:0] mem_instr, redirect_pc;
	logic [3:0] ra_sel, rb_sel, rd_sel;
	logic update_rd, alu_op1_ra, alu_op1_rb, alu_op2_rb;
	logic [31:0] imm32, pc_plus_4_out;
	logic [4:0] alu_opc;
	logic [2:0] branch_condition, cr_sel;
	logic [1:0] mem_width, instr_class;
	logic mem_load, mem_store, is_call, update_flags, update_carry;
	logic write_cr, is_swi, is_rfe, illegal_instr, exception_start_out;
	logic bkpt_hit, i_valid, queue_overflow;

	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	logic [31:0] exp_pc; // expected tag of the most recently accepted word

	always #(clk_period / 2) clk = ~clk;

	decode_frontend DUT (.*);

	task automatic step();
		@(posedge clk);
		#2; // inputs change and outputs are sampled well clear of the edge
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		check_count++;
		assert (got === want) else begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name, input int start);
		test_count++;
		if (error_count == start) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, error_count - start);
		end
	endtask

	function automatic logic [31:0] make_word(input logic [1:0] cls, input logic [4:0] opc);
		logic [31:0] w;
		w = $urandom();
		w[31:25] = {cls, opc};
		return w;
	endfunction

	function automatic expect_t model(input logic [31:0] w, input logic flt);
		expect_t e;
		logic [4:0] opc;
		opc = w[29:25];
		e = '0;
		e.ra = w[11:8];
		e.rb = w[7:4];
		e.rd = w[3:0];
		e.cls = w[31:30];
		e.cr = w[14:12];
		e.imm = 32'($signed(w[24:12]));
		case (w[31:30])
		class_arith: begin
			e.valid = opc inside {opc_add, opc_sub, opc_and, opc_or, opc_movhi, opc_orlo};
			e.update_rd = e.valid;
			e.alu_opc = e.valid ? opc : 5'd0;
			e.op1_ra = opc inside {opc_add, opc_sub, opc_and, opc_or, opc_orlo};
			e.op2_rb = opc inside {opc_add, opc_sub, opc_and, opc_or};
			e.update_flags = opc inside {opc_add, opc_sub, opc_and, opc_or};
			e.update_carry = opc inside {opc_add, opc_sub};
			if (opc == opc_movhi)
				e.imm = 32'(w[25:10]) << 16;
			if (opc == opc_orlo)
				e.imm = 32'(w[25:10]);
		end
		class_branch: begin
			e.valid = opc inside {opc_b, opc_call};
			if (e.valid) begin
				e.imm = 32'($signed(w[23:0])) << 2;
				e.cond = cond_always;
			end
			if (opc == opc_call) begin
				e.is_call = 1'b1;
				e.update_rd = 1'b1;
				e.rd = link_reg; // return address always lands in the link register
			end
		end
		class_mem: begin
			e.valid = opc inside {opc_ldr, opc_str};
			e.op1_ra = e.valid; // ra is the address base
			e.mem_load = opc == opc_ldr;
			e.mem_store = opc == opc_str;
			e.update_rd = opc == opc_ldr;
			e.mem_width = width_word;
		end
		default: begin
			e.valid = opc inside {opc_swi, opc_rfe, opc_bkp};
			e.is_swi = opc == opc_swi;
			e.is_rfe = opc == opc_rfe;
			e.bkpt = opc == opc_bkp;
		end
		endcase
		e.illegal = !e.valid;
		e.exc = !e.valid || e.is_swi || flt;
		e.i_valid = e.valid && !flt;
		if (flt) begin
			e.is_swi = 1'b0;
			e.is_rfe = 1'b0;
			e.is_call = 1'b0;
			e.bkpt = 1'b0;
			e.update_rd = 1'b0;
			e.update_flags = 1'b0;
			e.update_carry = 1'b0;
			e.mem_load = 1'b0;
			e.mem_store = 1'b0;
		end
		return e;
	endfunction

	task automatic compare_outputs(input logic [31:0] w, input expect_t e, input logic [31:0] pc);
		check_val("i_valid", 32'(i_valid), 32'(e.i_valid));
		check_val("illegal_instr", 32'(illegal_instr), 32'(e.illegal));
		check_val("exception_start_out", 32'(exception_start_out), 32'(e.exc));
		check_val("is_swi", 32'(is_swi), 32'(e.is_swi));
		check_val("is_rfe", 32'(is_rfe), 32'(e.is_rfe));
		check_val("is_call", 32'(is_call), 32'(e.is_call));
		check_val("bkpt_hit", 32'(bkpt_hit), 32'(e.bkpt));
		check_val("update_rd", 32'(update_rd), 32'(e.update_rd));
		check_val("update_flags", 32'(update_flags), 32'(e.update_flags));
		check_val("update_carry", 32'(update_carry), 32'(e.update_carry));
		check_val("write_cr", 32'(write_cr), 32'd0);
		check_val("alu_op1_ra", 32'(alu_op1_ra), 32'(e.op1_ra));
		check_val("alu_op1_rb", 32'(alu_op1_rb), 32'(e.op1_rb));
		check_val("alu_op2_rb", 32'(alu_op2_rb), 32'(e.op2_rb));
		check_val("branch_condition", 32'(branch_condition), 32'(e.cond));
		check_val("instr_class", 32'(instr_class), 32'(e.cls));
		check_val("cr_sel", 32'(cr_sel), 32'(e.cr));
		check_val("mem_load", 32'(mem_load), 32'(e.mem_load));
		check_val("mem_store", 32'(mem_store), 32'(e.mem_store));
		check_val("pc_plus_4_out", pc_plus_4_out, pc);
		check_val("ra_sel", 32'(ra_sel), 32'(e.ra));
		check_val("rb_sel", 32'(rb_sel), 32'(e.rb));
		check_val("rd_sel", 32'(rd_sel), 32'(e.rd));
		check_val("imm32", imm32, e.imm);
		if (w[31:30] == class_arith)
			check_val("alu_opc", 32'(alu_opc), 32'(e.alu_opc));
		if (w[31:30] == class_mem && e.valid)
			check_val("mem_width", 32'(mem_width), 32'(e.mem_width));
	endtask

	// strobes one word into an idle front end and checks it three cycles later
	task automatic run_word(input logic [31:0] w, input logic flt);
		expect_t e;
		e = model(w, flt);
		exp_pc = exp_pc + 32'd4;
		mem_instr = w;
		mem_fault = flt;
		mem_strobe = 1'b1;
		step();
		mem_strobe = 1'b0;
		mem_fault = 1'b0;
		check_val("i_valid one cycle after strobe", 32'(i_valid), 32'd0);
		step();
		check_val("i_valid two cycles after strobe", 32'(i_valid), 32'd0);
		step();
		compare_outputs(w, e, exp_pc);
	endtask

	task automatic wait_valid(input int limit, output bit seen);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			step();
			seen = i_valid;
		end
		check_count++;
		assert (seen) else begin
			$display("i_valid did not rise within %0d cycles", limit);
			error_count++;
		end
	endtask

	task automatic check_reset_state();
		check_val("i_valid", 32'(i_valid), 32'd0);
		check_val("update_rd", 32'(update_rd), 32'd0);
		check_val("update_flags", 32'(update_flags), 32'd0);
		check_val("update_carry", 32'(update_carry), 32'd0);
		check_val("mem_load", 32'(mem_load), 32'd0);
		check_val("mem_store", 32'(mem_store), 32'd0);
		check_val("is_call", 32'(is_call), 32'd0);
		check_val("is_swi", 32'(is_swi), 32'd0);
		check_val("is_rfe", 32'(is_rfe), 32'd0);
		check_val("write_cr", 32'(write_cr), 32'd0);
		check_val("exception_start_out", 32'(exception_start_out), 32'd0);
		check_val("bkpt_hit", 32'(bkpt_hit), 32'd0);
		check_val("queue_overflow", 32'(queue_overflow), 32'd0);
		check_val("pc_plus_4_out", pc_plus_4_out, 32'd0);
		check_val("fetch_in.strobe", 32'(DUT.fetch_in.strobe), 32'd0);
		check_val("decode_in.strobe", 32'(DUT.decode_in.strobe), 32'd0);
	endtask

	`include "tb_tasks.svh"

	initial begin
		void'($urandom(12));
		rst = 1'b1;
		mem_strobe = 1'b0;
		mem_instr = '0;
		mem_fault = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		hold = 1'b0;
		exp_pc = reset_vector;
		test_reset();
		test_arith();
		test_branch_mem();
		test_exceptions();
		test_hold();
		test_overflow();
		test_redirect();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		#(total_cycles * 2 * clk_period);
		$display("watchdog expired after %0d cycles before the tests finished", total_cycles * 2);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+tests
hw/oldland_pkg.sv
hw/fetch_bus_if.sv
hw/fetch_sequencer.sv
hw/instr_queue.sv
hw/instr_decode.sv
hw/decode_frontend.sv
tests/tb_decode_frontend.sv
